/* verilog/fm_regs_pkg.sv */
// fm_lite register map
// register addresses, busy length and timer constants

package fm_regs_pkg;

    // one byte per register, per-channel ones add the channel number
    typedef enum logic [7:0] {
        REG_TIMER_A   = 8'h24,
        REG_TIMER_B   = 8'h26,
        REG_TIMER_CTL = 8'h27,
        REG_KEY_ON    = 8'h28,
        REG_FNUM_LO   = 8'h30,
        REG_FNUM_HI   = 8'h34,
        REG_PAN       = 8'h38
    } reg_addr_e;

    localparam int BUSY_CYCLES = 4;     // clocks of busy after a data write
    localparam int BUSY_W = $clog2(BUSY_CYCLES + 1);

    localparam int TIMER_W = 8;         // both counters overflow at 255
    localparam int TIMER_B_PRESCALE = 16;
    localparam int PRE_W = $clog2(TIMER_B_PRESCALE);

endpackage

/* verilog/fm_voice_pkg.sv */
// fm_lite voice and mixer definitions
// channel count, data widths and the accumulator states

package fm_voice_pkg;

    localparam int NUM_CH = 4;
    localparam int CH_W = $clog2(NUM_CH);
    localparam int PHASE_W = 12;
    localparam int FNUM_W = 10;
    localparam int TL_W = 3;            // attenuation, arithmetic shift amount
    localparam int PAN_W = 2;           // bit 1 left, bit 0 right
    localparam int SAMPLE_W = 8;        // signed channel sample
    localparam int MIX_W = 9;           // signed stereo output
    localparam int SUM_W = MIX_W + 2;   // running sum, never overflows
    localparam int MIX_MAX = 2**(MIX_W - 1) - 1;

    // sample FIFO sizing as used at the top level
    localparam int FIFO_DEPTH = 8;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    typedef enum logic [1:0] {MIX_IDLE, MIX_ACC, MIX_OUT} mix_state_e;

endpackage

/* verilog/fm_mmr.sv */
// fm_lite CPU port
// address latch, register file, busy counter and status byte
`timescale 1ns/10ps

module fm_mmr (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [7:0]                   din,
    input  logic [1:0]                   addr,
    input  logic                         cs_n,
    input  logic                         wr_n,
    output logic [7:0]                   dout,
    input  logic                         flag_a,
    input  logic                         flag_b,
    output logic [fm_regs_pkg::TIMER_W-1:0] value_a,
    output logic [fm_regs_pkg::TIMER_W-1:0] value_b,
    output logic                         load_a,
    output logic                         load_b,
    output logic                         irq_en_a,
    output logic                         irq_en_b,
    output logic                         clr_a,
    output logic                         clr_b,
    output logic [fm_voice_pkg::NUM_CH-1:0][fm_voice_pkg::FNUM_W-1:0] fnum,
    output logic [fm_voice_pkg::NUM_CH-1:0][fm_voice_pkg::TL_W-1:0]   tl,
    output logic [fm_voice_pkg::NUM_CH-1:0]                           key_on,
    output logic [fm_voice_pkg::NUM_CH-1:0][fm_voice_pkg::PAN_W-1:0]  pan
);
    import fm_regs_pkg::*;
    import fm_voice_pkg::*;

    logic              write;
    logic              addr_wr;
    logic              data_wr;
    logic [7:0]        addr_q;      // latched register address
    logic [CH_W-1:0]   ch_sel;
    logic [7:0]        base;        // address with the channel bits masked
    logic [BUSY_W-1:0] busy_cnt;
    logic              busy;

    assign write   = !cs_n && !wr_n;
    assign addr_wr = write && (addr == 2'd0);
    assign data_wr = write && (addr == 2'd1);   // addr 2 and 3 ignored
    assign ch_sel  = addr_q[CH_W-1:0];
    assign base    = {addr_q[7:CH_W], {CH_W{1'b0}}};

    assign busy = (busy_cnt != '0);
    assign dout = {busy, 5'd0, flag_b, flag_a};

    always_ff @(posedge clk) begin
        if (reset) begin
            addr_q   <= '0;
            busy_cnt <= '0;
            value_a  <= '0;
            value_b  <= '0;
            {irq_en_b, irq_en_a, load_b, load_a} <= '0;
            clr_a    <= 1'b0;
            clr_b    <= 1'b0;
            key_on   <= '0;
            fnum     <= '0;
            tl       <= '0;
            pan      <= '0;
        end else begin
            clr_a <= 1'b0;      // flag clears last one cycle
            clr_b <= 1'b0;
            if (busy) busy_cnt <= busy_cnt - 1'b1;
            if (addr_wr) addr_q <= din;
            if (data_wr) begin
                busy_cnt <= BUSY_W'(BUSY_CYCLES);   // still accepted while busy
                case (addr_q)
                    REG_TIMER_A: value_a <= din;
                    REG_TIMER_B: value_b <= din;
                    REG_TIMER_CTL: begin
                        {irq_en_b, irq_en_a, load_b, load_a} <= din[3:0];
                        clr_a <= din[4];
                        clr_b <= din[5];
                    end
                    REG_KEY_ON: key_on <= din[NUM_CH-1:0];
                    default: begin
                        if (base == REG_FNUM_LO) fnum[ch_sel][7:0] <= din;
                        if (base == REG_FNUM_HI) begin
                            fnum[ch_sel][FNUM_W-1:8] <= din[FNUM_W-9:0];
                            tl[ch_sel] <= din[4 +: TL_W];
                        end
                        if (base == REG_PAN) pan[ch_sel] <= din[PAN_W-1:0];
                    end
                endcase
            end
        end
    end

endmodule

/* verilog/fm_timers.sv */
// fm_lite timers A and B
// up-counting reload timers with flags and an active-low irq
`timescale 1ns/10ps

module fm_timers (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            cen,
    input  logic [fm_regs_pkg::TIMER_W-1:0] value_a,
    input  logic [fm_regs_pkg::TIMER_W-1:0] value_b,
    input  logic                            load_a,
    input  logic                            load_b,
    input  logic                            irq_en_a,
    input  logic                            irq_en_b,
    input  logic                            clr_a,
    input  logic                            clr_b,
    output logic                            flag_a,
    output logic                            flag_b,
    output logic                            irq_n
);
    import fm_regs_pkg::*;

    // index 0 is timer A, index 1 is timer B
    logic [1:0][TIMER_W-1:0] value;
    logic [1:0][TIMER_W-1:0] cnt;
    logic [1:0]              load;
    logic [1:0]              irq_en;
    logic [1:0]              clr;
    logic [1:0]              tick;
    logic [1:0]              flag;
    logic [PRE_W-1:0]        pre_b;
    logic                    pre_wrap;

    assign value  = {value_b, value_a};
    assign load   = {load_b, load_a};
    assign irq_en = {irq_en_b, irq_en_a};
    assign clr    = {clr_b, clr_a};

    assign pre_wrap = (pre_b == PRE_W'(TIMER_B_PRESCALE - 1));
    assign tick[0]  = cen && load_a;
    assign tick[1]  = cen && load_b && pre_wrap;   // every 16th cen

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt   <= '0;
            flag  <= '0;
            pre_b <= '0;
        end else begin
            if (!load_b) pre_b <= '0;
            else if (cen) pre_b <= pre_wrap ? '0 : pre_b + 1'b1;
            for (int i = 0; i < 2; i++) begin
                if (clr[i]) flag[i] <= 1'b0;
                if (!load[i]) begin
                    cnt[i] <= value[i];     // stopped timers sit at their reload value
                end else if (tick[i]) begin
                    if (&cnt[i]) begin
                        cnt[i] <= value[i];
                        if (irq_en[i]) flag[i] <= 1'b1;
                    end else begin
                        cnt[i] <= cnt[i] + 1'b1;
                    end
                end
            end
        end
    end

    assign flag_a = flag[0];
    assign flag_b = flag[1];
    assign irq_n  = ~|flag;

endmodule

/* verilog/fm_tone_gen.sv */
// fm_lite tone generator
// sawtooth channels pushed into the sample FIFO one frame at a time
`timescale 1ns/10ps

module fm_tone_gen (
    input  logic clk,
    input  logic reset,
    input  logic [fm_voice_pkg::NUM_CH-1:0][fm_voice_pkg::FNUM_W-1:0] fnum,
    input  logic [fm_voice_pkg::NUM_CH-1:0][fm_voice_pkg::TL_W-1:0]   tl,
    input  logic [fm_voice_pkg::NUM_CH-1:0]                           key_on,
    input  logic [fm_voice_pkg::CNT_W-1:0]                            fifo_count,
    output logic                                                      push,
    output logic signed [fm_voice_pkg::SAMPLE_W-1:0]                  sample_out
);
    import fm_voice_pkg::*;

    logic                                run;    // frame in progress
    logic [CH_W-1:0]                     ch;
    logic [NUM_CH-1:0][PHASE_W-1:0]      phase;
    logic                                room;
    logic signed [SAMPLE_W-1:0]          saw;
    logic signed [SAMPLE_W-1:0]          att;

    // a whole frame must fit, pops only add room
    assign room = (fifo_count <= CNT_W'(FIFO_DEPTH - NUM_CH));

    // top phase bits with the msb flipped give a signed ramp
    assign saw = {~phase[ch][PHASE_W-1], phase[ch][PHASE_W-2 -: SAMPLE_W-1]};
    assign att = saw >>> tl[ch];

    assign push       = run;
    assign sample_out = key_on[ch] ? att : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            run   <= 1'b0;
            ch    <= '0;
            phase <= '0;
        end else if (run) begin
            // key off parks the phase at 0 so key on restarts the ramp
            if (key_on[ch]) phase[ch] <= phase[ch] + PHASE_W'(fnum[ch]);
            else            phase[ch] <= '0;
            ch <= ch + 1'b1;
            if (ch == CH_W'(NUM_CH - 1)) run <= 1'b0;
        end else if (room) begin
            run <= 1'b1;
            ch  <= '0;
        end
    end

endmodule

/* verilog/fm_sample_fifo.sv */
// fm_lite sample FIFO
// circular buffer between the tone generator and the mixer
`timescale 1ns/10ps

module fm_sample_fifo #(
    parameter int depth = 8
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                push,
    input  logic [fm_voice_pkg::SAMPLE_W-1:0]   din,
    input  logic                                pop,
    output logic [fm_voice_pkg::SAMPLE_W-1:0]   dout,
    output logic [$clog2(depth+1)-1:0]          count,
    output logic                                empty
);
    import fm_voice_pkg::*;

    localparam int PTR_W = $clog2(depth);

    logic [SAMPLE_W-1:0] mem [depth];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic                do_push;
    logic                do_pop;

    // pointers wrap at depth, not only powers of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign empty   = (count == '0);
    assign do_push = push && (count < depth);
    assign do_pop  = pop && !empty;
    assign dout    = mem[rd_ptr];       // show-ahead read

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= din;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)  rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* verilog/fm_acc.sv */
// fm_lite stereo accumulator
// pops one frame at cen rate, pans, sums and limits into left and right
`timescale 1ns/10ps

module fm_acc (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 cen,
    input  logic                                 empty,
    input  logic signed [fm_voice_pkg::SAMPLE_W-1:0] sample_in,
    input  logic [fm_voice_pkg::NUM_CH-1:0][fm_voice_pkg::PAN_W-1:0] pan,
    input  logic                                 limiter_en,
    output logic                                 pop,
    output logic signed [fm_voice_pkg::MIX_W-1:0] snd_left,
    output logic signed [fm_voice_pkg::MIX_W-1:0] snd_right,
    output logic                                 snd_sample
);
    import fm_voice_pkg::*;

    mix_state_e              state;
    logic [CH_W-1:0]         ch;
    logic signed [SUM_W-1:0] smp;
    logic signed [SUM_W-1:0] sum_l, sum_r;
    logic signed [SUM_W-1:0] nxt_l, nxt_r;

    // saturate with the limiter, otherwise wrap to the output width
    function automatic logic signed [MIX_W-1:0] limit(input logic signed [SUM_W-1:0] s,
                                                      input logic en);
        if (en && s > MIX_MAX)
            return MIX_W'(MIX_MAX);
        else if (en && s < -MIX_MAX - 1)
            return {1'b1, {(MIX_W-1){1'b0}}};
        else
            return s[MIX_W-1:0];
    endfunction

    assign pop   = cen && !empty;
    assign smp   = SUM_W'(sample_in);   // sign extended
    assign nxt_l = sum_l + (pan[ch][1] ? smp : '0);
    assign nxt_r = sum_r + (pan[ch][0] ? smp : '0);

    assign snd_sample = (state == MIX_OUT);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= MIX_IDLE;
            ch        <= '0;
            sum_l     <= '0;
            sum_r     <= '0;
            snd_left  <= '0;
            snd_right <= '0;
        end else if (pop) begin
            if (ch == CH_W'(NUM_CH - 1)) begin  // last channel closes the frame
                state     <= MIX_OUT;
                ch        <= '0;
                sum_l     <= '0;
                sum_r     <= '0;
                snd_left  <= limit(nxt_l, limiter_en);
                snd_right <= limit(nxt_r, limiter_en);
            end else begin
                state <= MIX_ACC;
                ch    <= ch + 1'b1;
                sum_l <= nxt_l;
                sum_r <= nxt_r;
            end
        end else if (state == MIX_OUT) begin
            state <= MIX_IDLE;      // one clock strobe
        end
    end

endmodule

/* verilog/fm_top.sv */
// fm_lite top level
// CPU port and timers, tone generator feeding the mixer through a FIFO
`timescale 1ns/10ps

module fm_top (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   cen,
    input  logic [7:0]                             din,
    input  logic [1:0]                             addr,
    input  logic                                   cs_n,
    input  logic                                   wr_n,
    input  logic                                   limiter_en,
    output logic [7:0]                             dout,
    output logic                                   irq_n,
    output logic signed [fm_voice_pkg::MIX_W-1:0]  snd_left,
    output logic signed [fm_voice_pkg::MIX_W-1:0]  snd_right,
    output logic                                   snd_sample
);
    import fm_regs_pkg::*;
    import fm_voice_pkg::*;

    // timers
    logic [TIMER_W-1:0] value_a, value_b;
    logic               load_a, load_b;
    logic               irq_en_a, irq_en_b;
    logic               clr_a, clr_b;
    logic               flag_a, flag_b;
    // channels
    logic [NUM_CH-1:0][FNUM_W-1:0] fnum;
    logic [NUM_CH-1:0][TL_W-1:0]   tl;
    logic [NUM_CH-1:0]             key_on;
    logic [NUM_CH-1:0][PAN_W-1:0]  pan;
    // sample path
    logic                       push, pop, fifo_empty;
    logic signed [SAMPLE_W-1:0] gen_sample;
    logic [SAMPLE_W-1:0]        fifo_dout;
    logic [CNT_W-1:0]           fifo_count;

    fm_mmr u_mmr (
        .clk        ( clk       ),
        .reset      ( reset     ),
        .din        ( din       ),
        .addr       ( addr      ),
        .cs_n       ( cs_n      ),
        .wr_n       ( wr_n      ),
        .dout       ( dout      ),
        .flag_a     ( flag_a    ),
        .flag_b     ( flag_b    ),
        .value_a    ( value_a   ),
        .value_b    ( value_b   ),
        .load_a     ( load_a    ),
        .load_b     ( load_b    ),
        .irq_en_a   ( irq_en_a  ),
        .irq_en_b   ( irq_en_b  ),
        .clr_a      ( clr_a     ),
        .clr_b      ( clr_b     ),
        .fnum       ( fnum      ),
        .tl         ( tl        ),
        .key_on     ( key_on    ),
        .pan        ( pan       )
    );

    fm_timers u_timers (
        .clk        ( clk       ),
        .reset      ( reset     ),
        .cen        ( cen       ),
        .value_a    ( value_a   ),
        .value_b    ( value_b   ),
        .load_a     ( load_a    ),
        .load_b     ( load_b    ),
        .irq_en_a   ( irq_en_a  ),
        .irq_en_b   ( irq_en_b  ),
        .clr_a      ( clr_a     ),
        .clr_b      ( clr_b     ),
        .flag_a     ( flag_a    ),
        .flag_b     ( flag_b    ),
        .irq_n      ( irq_n     )
    );

    fm_tone_gen u_tone_gen (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .fnum       ( fnum       ),
        .tl         ( tl         ),
        .key_on     ( key_on     ),
        .fifo_count ( fifo_count ),
        .push       ( push       ),
        .sample_out ( gen_sample )
    );

    fm_sample_fifo #(.depth(FIFO_DEPTH)) u_fifo (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .push       ( push       ),
        .din        ( gen_sample ),
        .pop        ( pop        ),
        .dout       ( fifo_dout  ),
        .count      ( fifo_count ),
        .empty      ( fifo_empty )
    );

    fm_acc u_acc (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .cen        ( cen        ),  // sets the output sample rate
        .empty      ( fifo_empty ),
        .sample_in  ( fifo_dout  ),
        .pan        ( pan        ),
        .limiter_en ( limiter_en ),
        .pop        ( pop        ),
        .snd_left   ( snd_left   ),
        .snd_right  ( snd_right  ),
        .snd_sample ( snd_sample )
    );

endmodule

/* tests/fm_asserts.sv */
// fm_lite sample FIFO checks
// count range and count bookkeeping, bound into the FIFO
`timescale 1ns/10ps

module fm_asserts #(
    parameter int depth = 8
) (
    input logic                       clk,
    input logic                       reset,
    input logic                       push,
    input logic                       pop,
    input logic [$clog2(depth+1)-1:0] count,
    input logic                       empty
);

    a_count_range: assert property (@(posedge clk) disable iff (reset) count <= depth)
        else $error("fifo count %0d above depth", count);

    // producer only pushes a frame when there is room
    a_no_overflow: assert property (@(posedge clk) disable iff (reset) push |-> count < depth)
        else $error("push into a full fifo");

    a_push_count: assert property (@(posedge clk) disable iff (reset)
        (push && !pop) |=> count == $past(count) + 1)
        else $error("fifo count did not rise on push");

    a_pop_count: assert property (@(posedge clk) disable iff (reset)
        (pop && !push && !empty) |=> count == $past(count) - 1)
        else $error("fifo count did not fall on pop");

    a_reset_empty: assert property (@(posedge clk) reset |=> empty)
        else $error("fifo not empty after reset");

endmodule

bind fm_sample_fifo fm_asserts #(.depth(depth)) u_fifo_asserts (
    .clk   ( clk   ),
    .reset ( reset ),
    .push  ( push  ),
    .pop   ( pop   ),
    .count ( count ),
    .empty ( empty )
);

/* tests/fm_tb.sv */
// fm_lite testbench
// drives the CPU port and cen, checks stereo frames against a reference model,
// then the timers, irq_n and the busy bit
`timescale 1ns/10ps

module fm_tb;
    import fm_regs_pkg::*;
    import fm_voice_pkg::*;

    logic clk, reset, cen, cs_n, wr_n, limiter_en;
    logic [7:0] din;
    logic [1:0] addr;
    logic [7:0] dout;
    logic irq_n, snd_sample;
    logic signed [MIX_W-1:0] snd_left, snd_right;

    int errors, checks, test_errors, test_checks, test_no;
    int cyc;
    logic cen_en;
    logic [15:0] lfsr_state;
    // channel setup as written to the DUT
    int t_fnum [NUM_CH];
    int t_tl [NUM_CH];
    int t_pan [NUM_CH];
    logic [NUM_CH-1:0] t_key;
    logic t_lim;
    int cmp_mode;   // 0 ignore, 1 expect silence, 2 align and compare
    logic aligned;
    int frame_idx, pulses;

    fm_top uut (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .cen        ( cen        ),
        .din        ( din        ),
        .addr       ( addr       ),
        .cs_n       ( cs_n       ),
        .wr_n       ( wr_n       ),
        .limiter_en ( limiter_en ),
        .dout       ( dout       ),
        .irq_n      ( irq_n      ),
        .snd_left   ( snd_left   ),
        .snd_right  ( snd_right  ),
        .snd_sample ( snd_sample )
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(negedge clk) begin
        cyc = cyc + 1;
        cen = cen_en && (cyc % 3 == 0);     // one cen every third clock
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_state[15]);
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    function automatic int out_value(input int s, input logic lim);
        int w;
        if (lim) return (s > 255) ? 255 : ((s < -256) ? -256 : s);
        w = s & 511;                        // wrap to 9 bits
        return (w > 255) ? w - 512 : w;
    endfunction

    // expected stereo pair for frame k after key-on
    function automatic void ref_frame(input int k, output int l, output int r);
        int ph;
        int s;
        l = 0;
        r = 0;
        for (int c = 0; c < NUM_CH; c++) begin
            if (t_key[c]) begin
                ph = (k * t_fnum[c]) % 4096;
                s = (ph >> 4) - 128;        // top byte, msb flipped
                s = s >>> t_tl[c];
                if (t_pan[c] & 2) l += s;
                if (t_pan[c] & 1) r += s;
            end
        end
        l = out_value(l, t_lim);
        r = out_value(r, t_lim);
    endfunction

    task automatic check(input string what, input integer got, input integer exp);
        checks++;
        test_checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("FAIL %0d ns: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic timeout_error(input string why);
        errors++;
        test_errors++;
        $display("timeout: %s", why);
    endtask

    always @(negedge clk) begin : compare
        int exp_l;
        int exp_r;
        if (!reset && snd_sample) begin
            pulses++;
            if (cmp_mode == 1) begin
                check("silent left", snd_left, 0);
                check("silent right", snd_right, 0);
            end else if (cmp_mode == 2) begin
                if (!aligned && (snd_left != 0 || snd_right != 0)) begin
                    aligned = 1'b1;
                    frame_idx = 0;
                end
                if (aligned) begin
                    ref_frame(frame_idx, exp_l, exp_r);
                    check($sformatf("frame %0d left", frame_idx), snd_left, exp_l);
                    check($sformatf("frame %0d right", frame_idx), snd_right, exp_r);
                    frame_idx++;
                end
            end
        end
    end

    task automatic bus_write(input logic [1:0] a, input logic [7:0] d);
        @(negedge clk);
        addr = a;
        din  = d;
        cs_n = 1'b0;
        wr_n = 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] r, input logic [7:0] d);
        bus_write(2'd0, r);
        bus_write(2'd1, d);
        @(negedge clk);
        cs_n = 1'b1;
        wr_n = 1'b1;
    endtask

    task automatic set_channel(input int ch, input int fnum, input int tl, input int pan);
        t_fnum[ch] = fnum;
        t_tl[ch] = tl;
        t_pan[ch] = pan;
        write_reg(8'(REG_FNUM_LO + ch), 8'(fnum));
        write_reg(8'(REG_FNUM_HI + ch), 8'((tl << 4) | (fnum >> 8)));
        write_reg(8'(REG_PAN + ch), 8'(pan));
    endtask

    task automatic wait_pulses(input int n);
        int start;
        int waited;
        start = pulses;
        waited = 0;
        while (pulses - start < n && waited < 40 * n) begin
            @(negedge clk);
            waited++;
        end
        if (pulses - start < n) timeout_error("snd_sample pulses stopped");
    endtask

    task automatic keys_off_drain();
        cmp_mode = 0;
        write_reg(REG_KEY_ON, 8'h00);
        wait_pulses(4);                     // frames already in the FIFO drain out
    endtask

    // stop cen and let the generator park with a full frame boundary
    task automatic hold_generator();
        int waited;
        cen_en = 1'b0;
        @(negedge clk);
        @(negedge clk);
        waited = 0;
        while (!(uut.fifo_count > NUM_CH && !uut.push) && waited < 50) begin
            @(negedge clk);
            waited++;
        end
        if (uut.push || uut.fifo_count <= NUM_CH) timeout_error("tone generator never idled");
    endtask

    task automatic run_keys(input logic [NUM_CH-1:0] keys, input logic lim, input int n);
        int waited;
        t_key = keys;
        t_lim = lim;
        limiter_en = lim;
        write_reg(REG_KEY_ON, 8'(keys));
        aligned = 1'b0;
        frame_idx = 0;
        cmp_mode = 2;
        cen_en = 1'b1;
        waited = 0;
        while (frame_idx < n && waited < 20 * (n + 4)) begin
            @(negedge clk);
            waited++;
        end
        if (frame_idx < n) timeout_error("frames stopped before the count was reached");
        cmp_mode = 0;
    endtask

    task automatic begin_test();
        test_errors = 0;
        test_checks = 0;
        test_no++;
    endtask

    task automatic end_test(input string name);
        $display("test %0d %s: %0d checks, %0d errors", test_no, name, test_checks,
                 test_errors);
    endtask

    task automatic timer_irq(input logic [7:0] val_reg, input int bit_no, input int limit);
        int waited;
        write_reg(val_reg, 8'(256 - 2 - bit_no * 4));   // a few ticks short of overflow
        write_reg(REG_TIMER_CTL, 8'(5 << bit_no));      // load and irq enable
        waited = 0;
        while (irq_n && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (irq_n) timeout_error("irq_n never went low");
        check("flag bit set", dout[bit_no], 1);
        write_reg(REG_TIMER_CTL, 8'(16 << bit_no));     // clear flag, timer stopped
        waited = 0;
        while (!irq_n && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        if (!irq_n) timeout_error("irq_n stayed low after the clear");
        check("flag bit cleared", dout[bit_no], 0);
    endtask

    initial begin
        int waited;
        int p;
        reset = 1'b1;
        cen = 1'b0;
        cen_en = 1'b0;
        din = '0;
        addr = '0;
        cs_n = 1'b1;
        wr_n = 1'b1;
        limiter_en = 1'b0;
        {errors, checks, test_errors, test_checks, test_no, cyc, pulses} = '0;
        cmp_mode = 0;
        aligned = 1'b0;
        frame_idx = 0;
        t_key = '0;
        t_lim = 1'b0;
        lfsr_state = 16'd94;
        repeat (3) @(negedge clk);
        reset = 1'b0;

        begin_test();
        check("dout after reset", dout, 0);
        check("irq_n after reset", irq_n, 1);
        cmp_mode = 1;
        cen_en = 1'b1;
        wait_pulses(5);
        end_test("reset state");

        begin_test();
        keys_off_drain();
        hold_generator();
        set_channel(0, rand_bits(FNUM_W), 0, 3);
        run_keys(4'b0001, 1'b0, 20);
        end_test("single tone");

        begin_test();
        keys_off_drain();
        hold_generator();
        for (int c = 0; c < NUM_CH; c++) begin
            p = rand_bits(PAN_W);
            set_channel(c, rand_bits(FNUM_W), rand_bits(TL_W), (p == 0) ? 3 : p);
        end
        run_keys(4'b1111, 1'b1, 30);
        end_test("random mix");

        begin_test();
        keys_off_drain();
        hold_generator();
        set_channel(0, 37, 0, 3);           // loud enough to pass 255
        set_channel(1, 101, 0, 3);
        set_channel(2, 200, 0, 3);
        set_channel(3, 5, 0, 2);
        run_keys(4'b1111, 1'b0, 30);
        keys_off_drain();
        hold_generator();
        run_keys(4'b1111, 1'b1, 30);
        end_test("loud mix, wrap then limiter");

        begin_test();
        keys_off_drain();
        cmp_mode = 1;
        wait_pulses(4);
        hold_generator();
        run_keys(4'b1010, 1'b1, 16);        // restart from phase 0
        end_test("key off and restart");

        begin_test();
        timer_irq(REG_TIMER_A, 0, 300);
        timer_irq(REG_TIMER_B, 1, 1500);
        end_test("timers and irq");

        begin_test();
        write_reg(REG_TIMER_A, 8'h00);
        check("busy after data write", dout[7], 1);
        waited = 0;
        while (dout[7] && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (dout[7]) timeout_error("busy never fell");
        check("busy length", waited, BUSY_CYCLES);
        end_test("busy");

        $display("%0d tests, %0d checks, %0d errors", test_no, checks, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

/* fm_lite.f */
verilog/fm_regs_pkg.sv
verilog/fm_voice_pkg.sv
verilog/fm_mmr.sv
verilog/fm_timers.sv
verilog/fm_tone_gen.sv
verilog/fm_sample_fifo.sv
verilog/fm_acc.sv
verilog/fm_top.sv
tests/fm_asserts.sv
tests/fm_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the fm_lite testbench with Verilator and run it
# exits nonzero when the build, the run or the log check fails

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module fm_tb \
    -f fm_lite.f -o fm_sim
if [ $? -ne 0 ]; then
    echo "verilator build did not complete"
    exit 1
fi

./obj_dir/fm_sim > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "Simulation failed" "$log"; then
    echo "log reports a failing run"
    exit 1
fi
if ! grep -q "Simulation completed successfully" "$log"; then
    echo "log has no final verdict"
    exit 1
fi
exit 0
